/* verilog/io_defines.svh */
// Sizing macros for the memory-mapped I/O request path
// Included by the package and by every module that sizes arrays by core or thread

`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// Cores sharing the I/O arbiter
// Each one owns a request queue
`define NUM_CORES 2

// Hardware threads per core
// One pending I/O entry each
`define THREADS_PER_CORE 4

// Scratch registers in the bank
// Word addresses 0 to 15, byte addresses 0 to 63
`define NUM_IO_REGS 16

// Bits needed to name a core
// Keep consistent with NUM_CORES
`define CORE_ID_WIDTH 1

`endif

/* verilog/io_pkg.sv */
// Shared types for the I/O request path and the one-hot helpers
// Compile before any module; modules import it in their body

`default_nettype none

`include "io_defines.svh"

package io_pkg;

	// Data and address word
	typedef logic [31:0] scalar_t;
	typedef logic [$clog2(`THREADS_PER_CORE)-1:0] thread_idx_t;
	typedef logic [`THREADS_PER_CORE-1:0] thread_bitmap_t;
	typedef logic [`CORE_ID_WIDTH-1:0] core_id_t;
	typedef logic [`NUM_CORES-1:0] core_bitmap_t;

	// Queue to arbiter
	typedef struct packed {
		logic valid;
		logic is_store;
		thread_idx_t thread_idx;
		scalar_t address;
		scalar_t value;
	} ioreq_packet_t;

	// Arbiter to register bank, tagged with source core
	typedef struct packed {
		ioreq_packet_t req;
		core_id_t core;
	} io_bus_request_t;

	// Bank response, broadcast to all cores
	typedef struct packed {
		logic valid;
		core_id_t core;
		thread_idx_t thread_idx;
		scalar_t read_value;
	} iorsp_packet_t;

	// One-hot to index, up to 32 inputs
	// Callers cast the result down to their own index type
	function automatic int unsigned oh_to_idx(input logic [31:0] one_hot);
		int unsigned index;
		index = 0;
		for (int i = 0; i < 32; i++)
		begin
			if (one_hot[i])
				index = index | unsigned'(i);
		end
		return index;
	endfunction

	// Index to one-hot, shift keeps the select width-clean
	function automatic logic [31:0] idx_to_oh(input int unsigned index);
		return 32'd1 << index;
	endfunction

endpackage

`default_nettype wire

/* verilog/rr_arbiter.sv */
// Round-robin arbiter with a one-hot grant
// Priority pointer moves past each winner; used per core for threads and
// at the top for cores

`default_nettype none

module rr_arbiter
	#(parameter int NUM_REQUESTERS = 4)
	(
	input logic clk,
	input logic reset,
	input logic [NUM_REQUESTERS-1:0] request,
	output logic [NUM_REQUESTERS-1:0] grant_oh
	);

	// Pointer width, at least one bit
	localparam int PTR_WIDTH = NUM_REQUESTERS > 1 ? $clog2(NUM_REQUESTERS) : 1;

	// Requester with highest priority this cycle
	logic [PTR_WIDTH-1:0] priority_ptr;
	logic [PTR_WIDTH-1:0] next_ptr;
	logic grant_valid;

	// First pass scans from the pointer up
	// Second pass wraps around below it
	always_comb
	begin
		grant_oh = '0;
		grant_valid = 1'b0;
		next_ptr = priority_ptr;
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int i = 0; i < NUM_REQUESTERS; i++)
			begin
				if (!grant_valid && request[i]
					&& ((pass == 0) == (i >= int'(priority_ptr))))
				begin
					grant_oh[i] = 1'b1;
					grant_valid = 1'b1;
					// Winner drops to lowest priority
					next_ptr = (i == NUM_REQUESTERS - 1) ? '0 : PTR_WIDTH'(i + 1);
				end
			end
		end
	end

	// Pointer only moves on a grant
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_ptr <= '0;
		else if (grant_valid)
			priority_ptr <= next_ptr;
	end

endmodule

`default_nettype wire

/* verilog/io_request_queue.sv */
// Per-core queue of non-cacheable I/O accesses
// First strobe from a thread records the access and rolls it back; the
// thread sleeps until the matching response wakes it, then its second
// strobe completes the access and returns the read value

`default_nettype none

`include "io_defines.svh"

module io_request_queue
	#(parameter io_pkg::core_id_t CORE_ID = '0)
	(
	input logic clk,
	input logic reset,

	// Dcache stage strobes
	input logic dd_io_write_en,
	input logic dd_io_read_en,
	input io_pkg::thread_idx_t dd_io_thread_idx,
	input io_pkg::scalar_t dd_io_addr,
	input io_pkg::scalar_t dd_io_write_value,

	// From io_arbiter
	input logic ia_ready,
	input io_pkg::iorsp_packet_t ia_response,

	// To io_arbiter
	output io_pkg::ioreq_packet_t ior_request,

	// To writeback and thread select
	output io_pkg::scalar_t ior_read_value,
	output logic ior_rollback_en,
	output io_pkg::thread_bitmap_t ior_wake_bitmap
	);

	import io_pkg::*;

	// Payload held while a thread waits
	typedef struct packed {
		logic is_store;
		scalar_t address;
		scalar_t value;
	} pending_payload_t;

	// Entry state, one bit per thread
	thread_bitmap_t entry_valid;
	thread_bitmap_t entry_sent;
	pending_payload_t entry_payload[`THREADS_PER_CORE];

	logic strobe;
	logic response_hit;
	logic send_fire;
	thread_bitmap_t strobe_oh;
	thread_bitmap_t record_oh;
	thread_bitmap_t response_oh;
	thread_bitmap_t send_request;
	thread_bitmap_t send_grant_oh;
	thread_bitmap_t sent_set;
	thread_idx_t send_grant_idx;

	// Decode the strobing thread
	assign strobe = dd_io_write_en || dd_io_read_en;
	assign strobe_oh = strobe ? thread_bitmap_t'(idx_to_oh(32'(dd_io_thread_idx))) : '0;

	// Strobe on an empty entry starts a new access
	assign record_oh = strobe_oh & ~entry_valid;

	// Responses for other cores are ignored
	assign response_hit = ia_response.valid && ia_response.core == CORE_ID;
	assign response_oh = response_hit
		? thread_bitmap_t'(idx_to_oh(32'(ia_response.thread_idx))) : '0;

	// Wake in the same cycle the response arrives
	assign ior_wake_bitmap = response_oh;

	// Only unsent entries compete
	assign send_request = entry_valid & ~entry_sent;

	rr_arbiter #(.NUM_REQUESTERS(`THREADS_PER_CORE)) send_arbiter (
		.clk(clk),
		.reset(reset),
		.request(send_request),
		.grant_oh(send_grant_oh)
	);

	assign send_grant_idx = thread_idx_t'(oh_to_idx(32'(send_grant_oh)));

	// Granted entry goes out to the arbiter
	assign ior_request = '{
		valid: |send_grant_oh,
		is_store: entry_payload[send_grant_idx].is_store,
		thread_idx: send_grant_idx,
		address: entry_payload[send_grant_idx].address,
		value: entry_payload[send_grant_idx].value
	};

	// Transfer happens only when the arbiter picks this core
	assign send_fire = ior_request.valid && ia_ready;
	assign sent_set = send_fire ? send_grant_oh : '0;

	// Strobe toggles valid between recorded and freed
	// New entries start unsent
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_sent <= '0;
		end
		else
		begin
			entry_valid <= entry_valid ^ strobe_oh;
			entry_sent <= (entry_sent & ~record_oh) | sent_set;
		end
	end

	// Capture on record, response overwrites value
	// Store responses bring back zero
	always_ff @(posedge clk)
	begin
		for (int t = 0; t < `THREADS_PER_CORE; t++)
		begin
			if (record_oh[t])
			begin
				entry_payload[t] <= '{
					is_store: dd_io_write_en,
					address: dd_io_addr,
					value: dd_io_write_value
				};
			end
			else if (response_oh[t])
				entry_payload[t].value <= ia_response.read_value;
		end
	end

	// Rollback on initiating strobe only
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			ior_rollback_en <= 1'b0;
		else
			ior_rollback_en <= |record_oh;
	end

	// Value seen by writeback on the completing strobe
	always_ff @(posedge clk)
		ior_read_value <= entry_payload[dd_io_thread_idx].value;

endmodule

`default_nettype wire

/* verilog/io_arbiter.sv */
// Shared arbiter between the per-core queues and the register bank
// Grants one valid core request per cycle, answers with a combinational
// ready bit, and registers the winner tagged with its core number

`default_nettype none

`include "io_defines.svh"

module io_arbiter (
	input logic clk,
	input logic reset,

	// From each core's request queue
	input io_pkg::ioreq_packet_t core_request[`NUM_CORES],
	output io_pkg::core_bitmap_t core_ready,

	// To the register bank
	output io_pkg::io_bus_request_t bus_request
	);

	import io_pkg::*;

	// Valid bits pulled out of the request structs
	core_bitmap_t core_valid;
	core_bitmap_t grant_oh;
	core_id_t grant_idx;

	// Registered bus request
	logic bus_valid;
	core_id_t bus_core;
	ioreq_packet_t bus_packet;

	always_comb
	begin
		for (int c = 0; c < `NUM_CORES; c++)
			core_valid[c] = core_request[c].valid;
	end

	rr_arbiter #(.NUM_REQUESTERS(`NUM_CORES)) core_arbiter (
		.clk(clk),
		.reset(reset),
		.request(core_valid),
		.grant_oh(grant_oh)
	);

	// Ready is the grant itself
	// Ungranted cores hold their request
	assign core_ready = grant_oh;
	assign grant_idx = core_id_t'(oh_to_idx(32'(grant_oh)));

	// Bus valid follows any grant
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			bus_valid <= 1'b0;
		else
			bus_valid <= |grant_oh;
	end

	// Winner's payload and core tag
	// Held when idle
	always_ff @(posedge clk)
	begin
		if (|grant_oh)
		begin
			bus_core <= grant_idx;
			bus_packet <= core_request[grant_idx];
		end
	end

	// Valid comes from the reset register, not the stale payload
	assign bus_request = '{
		req: '{
			valid: bus_valid,
			is_store: bus_packet.is_store,
			thread_idx: bus_packet.thread_idx,
			address: bus_packet.address,
			value: bus_packet.value
		},
		core: bus_core
	};

endmodule

`default_nettype wire

/* verilog/io_register_bank.sv */
// Bank of memory-mapped scratch registers on the I/O bus
// Every request gets a response one cycle later; addresses above the
// bank read as zero and drop writes

`default_nettype none

`include "io_defines.svh"

module io_register_bank (
	input logic clk,
	input logic reset,
	input io_pkg::io_bus_request_t bus_request,
	output io_pkg::iorsp_packet_t response
	);

	import io_pkg::*;

	// Word index is the address above the byte offset
	localparam int REG_IDX_WIDTH = $clog2(`NUM_IO_REGS);

	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

	scalar_t io_regs[`NUM_IO_REGS];
	reg_idx_t reg_idx;
	logic mapped;

	// Response registers
	logic rsp_valid;
	core_id_t rsp_core;
	thread_idx_t rsp_thread_idx;
	scalar_t rsp_read_value;

	// Address bits 5 to 2 select the word
	assign reg_idx = bus_request.req.address[REG_IDX_WIDTH+1:2];
	// Any upper bit set means unmapped
	assign mapped = bus_request.req.address[$bits(scalar_t)-1:REG_IDX_WIDTH+2] == '0;

	// Stores to mapped words only
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NUM_IO_REGS; i++)
				io_regs[i] <= '0;
		end
		else if (bus_request.req.valid && bus_request.req.is_store && mapped)
			io_regs[reg_idx] <= bus_request.req.value;
	end

	// One response per request, never stalls
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= bus_request.req.valid;
	end

	// Stores and unmapped loads answer zero
	always_ff @(posedge clk)
	begin
		if (bus_request.req.valid)
		begin
			rsp_core <= bus_request.core;
			rsp_thread_idx <= bus_request.req.thread_idx;
			if (bus_request.req.is_store || !mapped)
				rsp_read_value <= '0;
			else
				rsp_read_value <= io_regs[reg_idx];
		end
	end

	assign response = '{
		valid: rsp_valid,
		core: rsp_core,
		thread_idx: rsp_thread_idx,
		read_value: rsp_read_value
	};

endmodule

`default_nettype wire

/* verilog/io_subsystem.sv */
// Top of the I/O request path
// One request queue per core feeds the shared arbiter and register bank;
// the bank response is broadcast back to every queue

`default_nettype none

`include "io_defines.svh"

module io_subsystem (
	input logic clk,
	input logic reset,

	// Per-core dcache stage inputs
	input io_pkg::core_bitmap_t dd_io_write_en,
	input io_pkg::core_bitmap_t dd_io_read_en,
	input io_pkg::thread_idx_t dd_io_thread_idx[`NUM_CORES],
	input io_pkg::scalar_t dd_io_addr[`NUM_CORES],
	input io_pkg::scalar_t dd_io_write_value[`NUM_CORES],

	// Per-core results
	output io_pkg::scalar_t ior_read_value[`NUM_CORES],
	output io_pkg::core_bitmap_t ior_rollback_en,
	output io_pkg::thread_bitmap_t ior_wake_bitmap[`NUM_CORES]
	);

	import io_pkg::*;

	// Queue to arbiter
	ioreq_packet_t core_request[`NUM_CORES];
	core_bitmap_t core_ready;

	// Arbiter to bank, bank back to all queues
	io_bus_request_t bus_request;
	iorsp_packet_t response;

	for (genvar core_idx = 0; core_idx < `NUM_CORES; core_idx++)
	begin : core_gen
		io_request_queue #(.CORE_ID(core_id_t'(core_idx))) request_queue (
			.clk(clk),
			.reset(reset),
			.dd_io_write_en(dd_io_write_en[core_idx]),
			.dd_io_read_en(dd_io_read_en[core_idx]),
			.dd_io_thread_idx(dd_io_thread_idx[core_idx]),
			.dd_io_addr(dd_io_addr[core_idx]),
			.dd_io_write_value(dd_io_write_value[core_idx]),
			.ia_ready(core_ready[core_idx]),
			.ia_response(response),
			.ior_request(core_request[core_idx]),
			.ior_read_value(ior_read_value[core_idx]),
			.ior_rollback_en(ior_rollback_en[core_idx]),
			.ior_wake_bitmap(ior_wake_bitmap[core_idx])
		);
	end

	io_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.core_request(core_request),
		.core_ready(core_ready),
		.bus_request(bus_request)
	);

	io_register_bank register_bank (
		.clk(clk),
		.reset(reset),
		.bus_request(bus_request),
		.response(response)
	);

endmodule

`default_nettype wire

/* tests/io_subsystem_tb.sv */
// Directed testbench for the I/O request path
// Plays the dcache stage of every core, runs each thread as its own process
// and checks read values, rollback and wake bits against a register model

`default_nettype none

`include "io_defines.svh"

module io_subsystem_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import io_pkg::*;

	// Watchdog allows 2 us per test
	localparam int NUM_TESTS = 6;
	localparam int WAKE_LIMIT = 500;
	localparam int RANDOM_OPS = 6;
	localparam int NUM_THREADS = `NUM_CORES * `THREADS_PER_CORE;

	logic clk = 1'b0;
	logic reset;
	core_bitmap_t dd_io_write_en;
	core_bitmap_t dd_io_read_en;
	thread_idx_t dd_io_thread_idx[`NUM_CORES];
	scalar_t dd_io_addr[`NUM_CORES];
	scalar_t dd_io_write_value[`NUM_CORES];
	scalar_t ior_read_value[`NUM_CORES];
	core_bitmap_t ior_rollback_en;
	thread_bitmap_t ior_wake_bitmap[`NUM_CORES];

	// Expected register contents
	scalar_t reg_model[`NUM_IO_REGS];
	// One strobe per core per cycle
	core_bitmap_t core_busy;
	int error_count;
	int threads_done;

	io_subsystem UUT (.*);

	// 4 ns period
	always #2 clk = ~clk;

	task automatic check_scalar(input string name, input scalar_t got, input scalar_t expected);
		if (got !== expected)
		begin
			$display("[FAIL] %s: got %h, expected %h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("[FAIL] %s: got %h, expected %h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_bitmap(input string name, input thread_bitmap_t got,
		input thread_bitmap_t expected);
		if (got !== expected)
		begin
			$display("[FAIL] %s: got %h, expected %h", name, got, expected);
			error_count++;
		end
	endtask

	// Single strobe cycle on one core
	// Results sampled on the falling edge after the capturing rising edge
	task automatic strobe_core(input int core, input int thread, input logic is_store,
		input scalar_t address, input scalar_t value, output logic rollback,
		output scalar_t read_value);
		@(negedge clk);
		while (core_busy[core])
			@(negedge clk);
		core_busy[core] = 1'b1;
		dd_io_write_en[core] = is_store;
		dd_io_read_en[core] = !is_store;
		dd_io_thread_idx[core] = thread_idx_t'(thread);
		dd_io_addr[core] = address;
		dd_io_write_value[core] = value;
		@(negedge clk);
		dd_io_write_en[core] = 1'b0;
		dd_io_read_en[core] = 1'b0;
		rollback = ior_rollback_en[core];
		read_value = ior_read_value[core];
		core_busy[core] = 1'b0;
	endtask

	// Full access as a thread sees it
	// Initiate, sleep until woken, then complete
	task automatic do_io(input int core, input int thread, input logic is_store,
		input scalar_t address, input scalar_t value, output scalar_t result);
		logic rollback;
		logic woken;
		scalar_t first_value;
		thread_bitmap_t expected_wake;
		expected_wake = thread_bitmap_t'(1) << thread;
		woken = 1'b0;
		result = '0;
		strobe_core(core, thread, is_store, address, value, rollback, first_value);
		check_bit("ior_rollback_en", rollback, 1'b1);
		// Wake is a one-cycle pulse, so poll every cycle
		for (int i = 0; i < WAKE_LIMIT && !woken; i++)
		begin
			@(negedge clk);
			woken = ior_wake_bitmap[core][thread];
		end
		if (!woken)
		begin
			$display("Core %0d thread %0d was never woken after its I/O request", core, thread);
			error_count++;
		end
		else
		begin
			// Only the owner's bit, nothing on other cores
			for (int c = 0; c < `NUM_CORES; c++)
				check_bitmap("ior_wake_bitmap", ior_wake_bitmap[c], c == core ? expected_wake : '0);
			strobe_core(core, thread, is_store, address, value, rollback, result);
			check_bit("ior_rollback_en", rollback, 1'b0);
			// Stores come back as zero
			if (is_store)
				check_scalar("ior_read_value", result, '0);
		end
	endtask

	task automatic store_reg(input int core, input int thread, input int r, input scalar_t value);
		scalar_t result;
		do_io(core, thread, 1'b1, scalar_t'(r) << 2, value, result);
		reg_model[r] = value;
	endtask

	task automatic load_and_compare(input int core, input int thread, input int r);
		scalar_t result;
		do_io(core, thread, 1'b0, scalar_t'(r) << 2, '0, result);
		check_scalar("ior_read_value", result, reg_model[r]);
	endtask

	// First sample holds the reset values
	// Second sample follows two idle cycles
	task automatic test_reset_state();
		for (int sample = 0; sample < 2; sample++)
		begin
			if (sample == 1)
				repeat (2) @(negedge clk);
			for (int c = 0; c < `NUM_CORES; c++)
			begin
				check_bit("ior_rollback_en", ior_rollback_en[c], 1'b0);
				check_bitmap("ior_wake_bitmap", ior_wake_bitmap[c], '0);
			end
		end
	endtask

	task automatic test_store_load();
		store_reg(0, 1, 3, $urandom);
		load_and_compare(0, 1, 3);
		store_reg(1, 2, 7, $urandom);
		load_and_compare(1, 2, 7);
	endtask

	// 0x44 would alias word 1 if upper bits were ignored
	task automatic test_unmapped();
		scalar_t result;
		store_reg(0, 0, 0, $urandom);
		store_reg(1, 1, 1, $urandom);
		do_io(1, 3, 1'b1, 32'h0000_0044, $urandom, result);
		do_io(0, 2, 1'b1, 32'h8000_0000, $urandom, result);
		do_io(0, 0, 1'b0, 32'h0000_0040, '0, result);
		check_scalar("ior_read_value", result, '0);
		do_io(1, 0, 1'b0, 32'h0000_0044, '0, result);
		check_scalar("ior_read_value", result, '0);
		for (int r = 0; r < `NUM_IO_REGS; r++)
			load_and_compare(r % `NUM_CORES, r % `THREADS_PER_CORE, r);
	endtask

	// Mode 0 stores, mode 1 loads back, mode 2 random traffic
	task automatic thread_body(input int gt, input int mode);
		int core;
		int thread;
		int r;
		core = gt / `THREADS_PER_CORE;
		thread = gt % `THREADS_PER_CORE;
		if (mode == 0)
			store_reg(core, thread, 2 * gt + 1, {4'(gt), 28'($urandom)});
		else if (mode == 1)
			load_and_compare(core, thread, 2 * gt + 1);
		else
		begin
			// Thread owns words gt and gt+8, so order per word is fixed
			for (int i = 0; i < RANDOM_OPS; i++)
			begin
				r = gt + NUM_THREADS * int'($urandom & 1);
				if (($urandom & 1) != 0)
					store_reg(core, thread, r, $urandom);
				else
					load_and_compare(core, thread, r);
			end
		end
	endtask

	task automatic run_all_threads(input int mode);
		threads_done = 0;
		for (int g = 0; g < NUM_THREADS; g++)
		begin
			fork
				automatic int gt = g;
				begin
					thread_body(gt, mode);
					threads_done++;
				end
			join_none
		end
		wait (threads_done == NUM_THREADS);
	endtask

	task automatic test_all_threads();
		run_all_threads(0);
		run_all_threads(1);
	endtask

	task automatic test_random_traffic();
		run_all_threads(2);
	endtask

	initial
	begin
		void'($urandom(12));
		reset = 1'b1;
		dd_io_write_en = '0;
		dd_io_read_en = '0;
		core_busy = '0;
		error_count = 0;
		threads_done = 0;
		for (int c = 0; c < `NUM_CORES; c++)
		begin
			dd_io_thread_idx[c] = '0;
			dd_io_addr[c] = '0;
			dd_io_write_value[c] = '0;
		end
		// Bank resets to zero
		for (int r = 0; r < `NUM_IO_REGS; r++)
			reg_model[r] = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		test_reset_state();
		test_store_load();
		test_unmapped();
		test_all_threads();
		test_random_traffic();
		$display("Tests finished with %0d errors", error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Hang guard
	initial
	begin
		#(NUM_TESTS * 2000);
		$display("Timeout: run did not finish within %0d ns", NUM_TESTS * 2000);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/io_pkg.sv
verilog/rr_arbiter.sv
verilog/io_request_queue.sv
verilog/io_arbiter.sv
verilog/io_register_bank.sv
verilog/io_subsystem.sv
tests/io_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log, then grade the log

verilator --binary --timing -f vlog.f --top-module io_subsystem_tb -o io_subsystem_sim \
	&& ./obj_dir/io_subsystem_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; exit 1; }

cat sim.log

grep -q "Verification failed" sim.log \
	&& { echo "Simulation reported errors"; exit 1; } \
	|| { echo "Simulation clean"; exit 0; }
